/* source/vec_csr_config.svh */
`ifndef VEC_CSR_CONFIG_SVH
`define VEC_CSR_CONFIG_SVH

// scalar side
`define XLEN        32

// vector register length in bits
`define VLEN        512

// major opcodes seen by the register block
`define OPC_SYSTEM  7'h73   // csrrw / csrrs / csrrc and immediate forms
`define OPC_OP_V    7'h57   // vsetvli lives here with funct3 111

`endif

/* source/vec_csr_pkg.sv */
`include "vec_csr_config.svh"

package vec_csr_pkg;

    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [9:0]       vlen_cnt_t;   // element counts, max 512
    typedef logic [3:0]       mul_t;        // lmul / emul as integers
    typedef logic [6:0]       ew_t;         // element width in bits

    typedef enum logic [2:0] {
        LMUL_1    = 3'b000,
        LMUL_2    = 3'b001,
        LMUL_4    = 3'b010,
        LMUL_8    = 3'b011,
        LMUL_RSVD = 3'b100
    } vlmul_e;

    typedef enum logic [2:0] {
        EW8    = 3'b000,
        EW16   = 3'b001,
        EW32   = 3'b010,
        EW64   = 3'b011,
        EWRSVD = 3'b100
    } vew_e;

    typedef enum logic [11:0] {
        CSR_VSTART = 12'h008,
        CSR_VL     = 12'hC20,
        CSR_VTYPE  = 12'hC21
    } csr_addr_e;

    // funct3[1:0] only, the immediate bit does not matter here
    typedef enum logic [1:0] {
        OP_WRITE,
        OP_SET,
        OP_CLEAR,
        OP_NONE
    } csr_op_e;

    typedef struct packed {
        logic   ill;
        logic   vma;
        logic   vta;
        vew_e   vsew;
        vlmul_e vlmul;
    } vtype_s;

    // same bit layout as the 32-bit instruction word
    typedef struct packed {
        csr_addr_e  csr_addr;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } insn_s;

    typedef struct packed {
        mul_t      vlmul;
        ew_t       sew;
        vlen_cnt_t vlmax;
    } vec_cfg_s;

    typedef struct packed {
        ew_t       eew;
        mul_t      emul;
        vlen_cnt_t e_vlmax;
    } mem_cfg_s;

    // reserved lmul counts as 1, reserved sew as 32
    function automatic vec_cfg_s decode_vec_cfg(vtype_s vt);
        vec_cfg_s cfg;
        case (vt.vlmul)
            LMUL_2:  cfg.vlmul = 4'd2;
            LMUL_4:  cfg.vlmul = 4'd4;
            LMUL_8:  cfg.vlmul = 4'd8;
            default: cfg.vlmul = 4'd1;
        endcase
        case (vt.vsew)
            EW8:     cfg.sew = 7'd8;
            EW16:    cfg.sew = 7'd16;
            EW64:    cfg.sew = 7'd64;
            default: cfg.sew = 7'd32;
        endcase
        cfg.vlmax = vlen_cnt_t'((`VLEN / cfg.sew) * cfg.vlmul);   // at most 512
        return cfg;
    endfunction

endpackage

/* source/commit_ctrl.sv */
`timescale 1ns/1ps
`include "vec_csr_config.svh"

module commit_ctrl (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               csrwr_en,
    input  vec_csr_pkg::insn_s insn,
    output logic               cfg_commit,
    output logic               csr_commit,
    output logic               csr_done
);
    import vec_csr_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        DONE,
        HOLD
    } commit_state_e;

    commit_state_e state_q;
    commit_state_e state_d;
    logic          commit;

    // only the first edge of a high enable level commits
    assign commit     = (state_q == IDLE) && csrwr_en;
    assign cfg_commit = commit && (insn.opcode == `OPC_OP_V) && (insn.funct3 == 3'b111);
    assign csr_commit = commit && (insn.opcode == `OPC_SYSTEM);
    assign csr_done   = (state_q == DONE);   // one cycle after the commit edge

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (csrwr_en) state_d = DONE;
            DONE:    state_d = csrwr_en ? HOLD : IDLE;
            HOLD:    if (!csrwr_en) state_d = IDLE;   // wait for enable to drop
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // a held enable must never stretch or repeat the done pulse
    a_done_single: assert property (@(posedge clk) disable iff (!n_rst)
        csr_done |=> !csr_done);

endmodule

/* source/vtype_regs.sv */
`timescale 1ns/1ps

module vtype_regs (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  cfg_commit,
    input  vec_csr_pkg::insn_s    insn,
    input  vec_csr_pkg::xlen_t    scalar1,   // avl
    input  vec_csr_pkg::xlen_t    scalar2,   // new vtype
    output vec_csr_pkg::vtype_s   vtype,
    output vec_csr_pkg::xlen_t    vl,
    output vec_csr_pkg::vec_cfg_s vec_cfg
);
    import vec_csr_pkg::*;

    localparam vtype_s VTYPE_RST = '{
        ill:   1'b1,
        vma:   1'b0,
        vta:   1'b0,
        vsew:  EW8,
        vlmul: LMUL_1
    };

    vtype_s   vtype_q;
    vtype_s   vtype_new;
    xlen_t    vl_q;
    xlen_t    vlmax_new;
    xlen_t    avl_clip;
    vec_cfg_s cfg_new;
    logic     rs1_zero;
    logic     rd_zero;

    //////////////////////////////
    // new configuration
    //////////////////////////////

    // low byte of scalar2 maps straight onto vma/vta/vsew/vlmul
    assign vtype_new = vtype_s'({1'b0, scalar2[7:0]});
    assign cfg_new   = decode_vec_cfg(vtype_new);
    assign vlmax_new = xlen_t'(cfg_new.vlmax);

    assign avl_clip = (scalar1 > vlmax_new) ? vlmax_new : scalar1;
    assign rs1_zero = (insn.rs1 == 5'd0);
    assign rd_zero  = (insn.rd == 5'd0);

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            vtype_q <= VTYPE_RST;
            vl_q    <= '0;
        end else if (cfg_commit) begin
            vtype_q <= vtype_new;
            if (!rs1_zero) begin
                vl_q <= avl_clip;
            end else if (!rd_zero) begin
                vl_q <= vlmax_new;       // request for the full vlmax
            end
            // rs1 = rd = x0 keeps the old vl
        end
    end

    //////////////////////////////
    // stored configuration
    //////////////////////////////

    assign vtype   = vtype_q;
    assign vl      = vl_q;
    assign vec_cfg = decode_vec_cfg(vtype_q);

    // the keep-vl form is excluded, it may legally leave vl above a new vlmax
    a_vl_in_range: assert property (@(posedge clk) disable iff (!n_rst)
        (cfg_commit && !(rs1_zero && rd_zero)) |=> (vl_q <= xlen_t'(vec_cfg.vlmax)));

endmodule

/* source/mem_elem_decode.sv */
`timescale 1ns/1ps
`include "vec_csr_config.svh"

module mem_elem_decode (
    input  vec_csr_pkg::vtype_s   vtype,
    input  logic [2:0]            width,    // width field of the memory insn
    output vec_csr_pkg::mem_cfg_s mem_cfg
);
    import vec_csr_pkg::*;

    vec_cfg_s    cur_cfg;
    ew_t         eew;
    mul_t        emul;
    int unsigned emul_raw;

    assign cur_cfg = decode_vec_cfg(vtype);

    always_comb begin
        case (width)
            3'b000:  eew = 7'd8;
            3'b101:  eew = 7'd16;
            3'b110:  eew = 7'd32;
            3'b111:  eew = 7'd64;
            default: eew = 7'd32;
        endcase

        // emul = eew / sew * lmul, fractions truncate to 0
        emul_raw = (int'(eew) * int'(cur_cfg.vlmul)) / int'(cur_cfg.sew);
        if (emul_raw < 1 || emul_raw > 8) begin
            emul = 4'd1;                    // out of range falls back to 1
        end else begin
            emul = mul_t'(emul_raw);
        end

        // an in-range emul keeps the element count of the register group
        a_emul_group: assert (emul_raw < 1 || emul_raw > 8 ||
                              (`VLEN / eew) * emul == (`VLEN / cur_cfg.sew) * cur_cfg.vlmul);
    end

    assign mem_cfg.eew     = eew;
    assign mem_cfg.emul    = emul;
    assign mem_cfg.e_vlmax = vlen_cnt_t'((`VLEN / eew) * emul);

endmodule

/* source/csr_access.sv */
`timescale 1ns/1ps
`include "vec_csr_config.svh"

module csr_access (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                csr_commit,
    input  vec_csr_pkg::insn_s  insn,
    input  vec_csr_pkg::xlen_t  scalar1,    // rs1 value or zimm
    input  vec_csr_pkg::vtype_s vtype,
    input  vec_csr_pkg::xlen_t  vl,
    output vec_csr_pkg::xlen_t  vstart,
    output vec_csr_pkg::xlen_t  csr_out
);
    import vec_csr_pkg::*;

    csr_op_e csr_op;
    xlen_t   vstart_q;
    xlen_t   vstart_d;
    xlen_t   vtype_word;
    logic    rs1_zero;
    logic    is_system;

    assign rs1_zero  = (insn.rs1 == 5'd0);
    assign is_system = (insn.opcode == `OPC_SYSTEM);

    always_comb begin
        case (insn.funct3[1:0])
            2'b01:   csr_op = OP_WRITE;
            2'b10:   csr_op = OP_SET;
            2'b11:   csr_op = OP_CLEAR;
            default: csr_op = OP_NONE;
        endcase
    end

    //////////////////////////////
    // vstart
    //////////////////////////////

    always_comb begin
        vstart_d = vstart_q;
        case (csr_op)
            OP_WRITE: vstart_d = scalar1;
            OP_SET:   vstart_d = vstart_q | scalar1;
            OP_CLEAR: vstart_d = vstart_q & ~scalar1;
            default:  vstart_d = vstart_q;
        endcase
    end

    // holds between csr writes
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            vstart_q <= '0;
        end else if (csr_commit && insn.csr_addr == CSR_VSTART) begin
            vstart_q <= vstart_d;
        end
    end

    assign vstart = vstart_q;

    //////////////////////////////
    // read mux
    //////////////////////////////

    // ill on top, rest of the upper bits zero
    assign vtype_word = {vtype.ill, {(`XLEN-9){1'b0}},
                         vtype.vma, vtype.vta, vtype.vsew, vtype.vlmul};

    always_comb begin
        csr_out = '0;
        if (is_system && csr_op != OP_NONE) begin
            case (insn.csr_addr)
                CSR_VSTART: csr_out = vstart_q;    // old value before commit
                CSR_VTYPE:  if (csr_op != OP_WRITE && rs1_zero) csr_out = vtype_word;
                CSR_VL:     if (csr_op != OP_WRITE && rs1_zero) csr_out = vl;
                default:    csr_out = '0;
            endcase
        end
    end

endmodule

/* source/vec_csr_regfile.sv */
`timescale 1ns/1ps

module vec_csr_regfile (
    input  logic                   clk,
    input  logic                   n_rst,
    input  vec_csr_pkg::xlen_t     inst,
    input  vec_csr_pkg::xlen_t     scalar1,
    input  vec_csr_pkg::xlen_t     scalar2,
    input  logic [2:0]             width,
    input  logic                   csrwr_en,
    output vec_csr_pkg::xlen_t     csr_out,
    output vec_csr_pkg::mul_t      vlmul,
    output vec_csr_pkg::mul_t      emul,
    output vec_csr_pkg::ew_t       sew,
    output vec_csr_pkg::ew_t       eew,
    output vec_csr_pkg::vlen_cnt_t vlmax,
    output vec_csr_pkg::vlen_cnt_t e_vlmax,
    output logic                   tail_agnostic,
    output logic                   mask_agnostic,
    output vec_csr_pkg::xlen_t     vec_length,
    output vec_csr_pkg::xlen_t     start_element,
    output logic                   csr_done
);
    import vec_csr_pkg::*;

    insn_s    insn;
    logic     cfg_commit;
    logic     csr_commit;
    vtype_s   vtype;
    xlen_t    vl;
    vec_cfg_s vec_cfg;
    mem_cfg_s mem_cfg;

    assign insn = insn_s'(inst);   // field overlay of the raw word

    commit_ctrl u_commit_ctrl (
        .clk        (clk),
        .n_rst      (n_rst),
        .csrwr_en   (csrwr_en),
        .insn       (insn),
        .cfg_commit (cfg_commit),
        .csr_commit (csr_commit),
        .csr_done   (csr_done)
    );

    vtype_regs u_vtype_regs (
        .clk        (clk),
        .n_rst      (n_rst),
        .cfg_commit (cfg_commit),
        .insn       (insn),
        .scalar1    (scalar1),
        .scalar2    (scalar2),
        .vtype      (vtype),
        .vl         (vl),
        .vec_cfg    (vec_cfg)
    );

    mem_elem_decode u_mem_elem_decode (
        .vtype   (vtype),
        .width   (width),
        .mem_cfg (mem_cfg)
    );

    csr_access u_csr_access (
        .clk        (clk),
        .n_rst      (n_rst),
        .csr_commit (csr_commit),
        .insn       (insn),
        .scalar1    (scalar1),
        .vtype      (vtype),
        .vl         (vl),
        .vstart     (start_element),
        .csr_out    (csr_out)
    );

    // flat outputs for the rest of the unit
    assign vlmul         = vec_cfg.vlmul;
    assign sew           = vec_cfg.sew;
    assign vlmax         = vec_cfg.vlmax;
    assign eew           = mem_cfg.eew;
    assign emul          = mem_cfg.emul;
    assign e_vlmax       = mem_cfg.e_vlmax;
    assign tail_agnostic = vtype.vta;
    assign mask_agnostic = vtype.vma;
    assign vec_length    = vl;

endmodule

/* testbench/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
    output logic clk
);
    localparam int HALF_PERIOD_NS = 5;   // 10 ns period

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

/* testbench/vec_csr_tb.sv */
`timescale 1ns/1ps

module vec_csr_tb;
    import vec_csr_pkg::*;

    // one line of the vector file
    typedef struct packed {
        xlen_t      inst;
        xlen_t      scalar1;
        xlen_t      scalar2;
        logic [2:0] width;
        logic [3:0] hold;            // edges with csrwr_en high
        xlen_t      csr_out;
        xlen_t      vec_length;
        vlen_cnt_t  vlmax;
        ew_t        sew;
        mul_t       vlmul;
        ew_t        eew;
        mul_t       emul;
        vlen_cnt_t  e_vlmax;
        xlen_t      start_element;
        logic       tail_agnostic;
        logic       mask_agnostic;
    } vec_line_s;

    logic      clk;
    logic      n_rst;
    xlen_t     inst;
    xlen_t     scalar1;
    xlen_t     scalar2;
    logic [2:0] width;
    logic      csrwr_en;
    xlen_t     csr_out;
    mul_t      vlmul;
    mul_t      emul;
    ew_t       sew;
    ew_t       eew;
    vlen_cnt_t vlmax;
    vlen_cnt_t e_vlmax;
    logic      tail_agnostic;
    logic      mask_agnostic;
    xlen_t     vec_length;
    xlen_t     start_element;
    logic      csr_done;

    vec_line_s vectors[$];
    bit        vectors_loaded = 1'b0;

    clk_gen u_clk_gen (.clk(clk));

    vec_csr_regfile vec_csr_regfile_inst (.*);

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_run($sformatf("mismatch at %0t ns: %s is %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [16];
        vec_line_s   v;
        fd = $fopen("testbench/vec_csr_input.txt", "r");
        if (fd == 0) begin
            stop_run("could not open the vector file testbench/vec_csr_input.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin   // skip comments
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
                    if (n != 16 || f[4] == 0) begin
                        stop_run($sformatf("malformed vector line: %s", line));
                    end else begin
                        v.inst          = f[0];
                        v.scalar1       = f[1];
                        v.scalar2       = f[2];
                        v.width         = f[3][2:0];
                        v.hold          = f[4][3:0];
                        v.csr_out       = f[5];
                        v.vec_length    = f[6];
                        v.vlmax         = f[7][9:0];
                        v.sew           = f[8][6:0];
                        v.vlmul         = f[9][3:0];
                        v.eew           = f[10][6:0];
                        v.emul          = f[11][3:0];
                        v.e_vlmax       = f[12][9:0];
                        v.start_element = f[13];
                        v.tail_agnostic = f[14][0];
                        v.mask_agnostic = f[15][0];
                        vectors.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // everything that settles at the commit edge
    task automatic check_outputs(input vec_line_s v);
        check_value("vec_length", vec_length, v.vec_length);
        check_value("vlmax", 32'(vlmax), 32'(v.vlmax));
        check_value("sew", 32'(sew), 32'(v.sew));
        check_value("vlmul", 32'(vlmul), 32'(v.vlmul));
        check_value("eew", 32'(eew), 32'(v.eew));
        check_value("emul", 32'(emul), 32'(v.emul));
        check_value("e_vlmax", 32'(e_vlmax), 32'(v.e_vlmax));
        check_value("start_element", start_element, v.start_element);
        check_value("tail_agnostic", 32'(tail_agnostic), 32'(v.tail_agnostic));
        check_value("mask_agnostic", 32'(mask_agnostic), 32'(v.mask_agnostic));
    endtask

    task automatic sample_done(input vec_line_s v, inout int pulses);
        if (csr_done) begin
            pulses++;
            if (pulses == 1) check_outputs(v);   // values of the done cycle
        end
    endtask

    //////////////////////////////
    // one instruction
    //////////////////////////////

    task automatic run_vector(input vec_line_s v);
        int pulses;
        int e;
        pulses = 0;
        @(posedge clk);
        #1;
        inst     = v.inst;
        scalar1  = v.scalar1;
        scalar2  = v.scalar2;
        width    = v.width;
        csrwr_en = 1'b1;
        @(negedge clk);
        check_value("csr_out", csr_out, v.csr_out);   // old value, before the commit
        for (e = 0; e < int'(v.hold); e++) begin
            @(posedge clk);
            #1;
            scalar1 = ~v.scalar1;                      // a repeated commit would land in vstart
            if (e == int'(v.hold) - 1) csrwr_en = 1'b0;
            @(negedge clk);
            sample_done(v, pulses);
        end
        while (pulses == 0) begin                      // watchdog covers a lost done
            @(negedge clk);
            sample_done(v, pulses);
        end
        @(negedge clk);
        sample_done(v, pulses);                        // catches a stretched pulse
        check_value("csr_done pulses", 32'(pulses), 32'd1);
    endtask

    //////////////////////////////
    // main sequence and watchdog
    //////////////////////////////

    initial begin
        n_rst    = 1'b0;
        csrwr_en = 1'b0;
        inst     = '0;
        scalar1  = '0;
        scalar2  = '0;
        width    = '0;
        load_vectors();
        if (vectors.size() == 0) stop_run("the vector file holds no vectors");
        vectors_loaded = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        n_rst = 1'b1;
        @(negedge clk);
        check_value("csr_done", 32'(csr_done), 32'd0);
        check_value("vec_length", vec_length, 32'd0);
        check_value("start_element", start_element, 32'd0);
        foreach (vectors[i]) run_vector(vectors[i]);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        wait (vectors_loaded);
        repeat (vectors.size() * 20 + 50) @(posedge clk);
        stop_run("timeout: the run did not finish within the cycle budget");
    end

endmodule

/* testbench/vec_csr_input.txt */
# stimulus: inst scalar1 scalar2 width hold (edges with csrwr_en high)
# expected: csr_out vl vlmax sew vlmul eew emul e_vlmax vstart ta ma, all hex
C21020F3 0 0 0 1 80000000 0 40 8 1 8 1 40 0 0 0
000170D7 64 51 6 1 0 20 20 20 2 20 2 20 0 1 0
000170D7 A C3 7 1 0 A 200 8 8 40 1 8 0 1 1
000070D7 5 8A 0 1 0 80 80 10 4 8 2 80 0 0 1
000170D7 3E8 2E 5 1 0 10 10 20 1 10 1 20 0 0 0
00007057 7 58 3 1 0 10 8 40 1 20 1 10 0 1 0
C21020F3 0 0 7 1 58 10 8 40 1 40 1 8 0 1 0
C20020F3 0 0 6 1 10 10 8 40 1 20 1 10 0 1 0
008110F3 2C 0 0 1 0 10 8 40 1 8 1 40 2C 1 0
008120F3 13 0 0 1 2C 10 8 40 1 8 1 40 3F 1 0
008130F3 A 0 0 1 3F 10 8 40 1 8 1 40 35 1 0
0082D0F3 5 0 0 1 35 10 8 40 1 8 1 40 5 1 0
008C60F3 18 0 0 1 5 10 8 40 1 8 1 40 1D 1 0
008670F3 C 0 0 1 1D 10 8 40 1 8 1 40 11 1 0
C20120F3 FF 0 0 1 0 10 8 40 1 8 1 40 11 1 0
C21110F3 3 0 0 1 0 10 8 40 1 8 1 40 11 1 0
00510093 77 FF 0 1 0 10 8 40 1 8 1 40 11 1 0
02000057 0 FF 0 1 0 10 8 40 1 8 1 40 11 1 0
008120F3 40 0 0 3 11 10 8 40 1 8 1 40 51 1 0
008020F3 0 0 0 1 51 10 8 40 1 8 1 40 51 1 0

/* sim.f */
+incdir+source
source/vec_csr_pkg.sv
source/commit_ctrl.sv
source/vtype_regs.sv
source/mem_elem_decode.sv
source/csr_access.sv
source/vec_csr_regfile.sv
testbench/clk_gen.sv
testbench/vec_csr_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module vec_csr_tb -o vec_csr_sim

status=0
sim_out=$(./obj_dir/vec_csr_sim 2>&1) || status=$?
echo "$sim_out"

if grep -q "ALL CHECKS PASSED" <<< "$sim_out"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, exit status $status"
exit 1
